//--- src.f
hdl/rob_pkg.sv
hdl/rob_entry.sv
hdl/rob_alloc_ctrl.sv
hdl/rob_commit_ctrl.sv
hdl/rob_top.sv
bench/tb_rob.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_rob -f src.f -o tb_rob_sim &&
{
  sim_out=$(./obj_dir/tb_rob_sim)
  echo "$sim_out"
  echo "$sim_out" | grep -qx "TEST PASSED"
} ||
{ echo "Simulation failed"; exit 1; }

//--- bench/tb_rob.sv
module tb_rob;

  timeunit 1ns;
  timeprecision 100ps;

  import rob_pkg::*;

  localparam int N_ROWS  = 6;
  localparam int MAX_GRP = 9;
  localparam int N_PORTS = 2;

  // Per-group fields hold one entry per group, group 0 in the low bits.
  typedef struct packed {
    logic [3:0]                      n_grp;
    logic [3:0]                      exp_commits;
    logic                            exp_full;
    logic [MAX_GRP-1:0][1:0]         mask;
    logic [VADDR_W-1:1]              pc_base;
    logic [MAX_GRP-1:0]              tlb_valid;
    logic [3:0]                      tlb_cause;
    logic [MAX_GRP-1:0][1:0]         exc_valid;
    logic [DISP_SIZE-1:0][3:0]       exc_type;
    logic                            complete;
    logic                            reverse;
    logic                            br_valid;
    logic [3:0]                      br_grp;
    logic                            br_slot;
    logic [VADDR_W-1:0]              br_vaddr;
    logic                            kill_valid;
    logic [3:0]                      kill_at;
  } scen_t;

  logic                i_clk;
  logic                i_reset_n;
  logic                i_disp_valid;
  disp_grp_t           i_disp;
  done_rpt_t           i_done_rpt [N_PORTS];
  br_upd_t             i_br_upd;
  logic                i_kill;
  logic                o_disp_ready;
  logic [CMT_ID_W-1:0] o_disp_cmt_id;
  logic                o_commit_valid;
  commit_t             o_commit;

  scen_t               rows [N_ROWS];
  string               row_name [N_ROWS] = '{"in_order", "done_exc", "tlb_exc", "kill",
                                             "flow_ctrl", "branch"};
  logic                table_built = 1'b0;
  logic [CMT_ID_W-1:0] next_id;
  logic [15:0]         lfsr_q = 16'd55955;
  commit_t             got_q [$];
  int                  commit_cnt = 0;

  rob_top u_dut (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp         (i_disp),
    .i_done_rpt     (i_done_rpt),
    .i_br_upd       (i_br_upd),
    .i_kill         (i_kill),
    .o_disp_ready   (o_disp_ready),
    .o_disp_cmt_id  (o_disp_cmt_id),
    .o_commit_valid (o_commit_valid),
    .o_commit       (o_commit)
  );

  initial begin
    i_clk = 1'b0;
    forever #5 i_clk = ~i_clk;
  end

  // Commit records are registered, so the falling edge sees them settled.
  always @(negedge i_clk) begin
    if (o_commit_valid) begin
      got_q.push_back(o_commit);
      commit_cnt++;
    end
  end

  task automatic build_table();
    rows[0] = '{n_grp: 4'd3, exp_commits: 4'd3, mask: 18'b00_00_00_00_00_00_11_01_11,
                pc_base: 38'h1000, complete: 1'b1, reverse: 1'b1, default: '0};
    rows[1] = '{n_grp: 4'd2, exp_commits: 4'd2, mask: 18'b00_00_00_00_00_00_00_10_11,
                exc_valid: 18'b00_00_00_00_00_00_00_11_11,
                exc_type: {EXC_ECALL, EXC_ILLEGAL_INST},
                pc_base: 38'h2000, complete: 1'b1, default: '0};
    rows[2] = '{n_grp: 4'd2, exp_commits: 4'd2, mask: 18'b00_00_00_00_00_00_00_10_11,
                tlb_valid: 9'b0_0000_0011, tlb_cause: EXC_INST_PAGE_FAULT,
                pc_base: 38'h3000, complete: 1'b1, default: '0};
    rows[3] = '{n_grp: 4'd3, exp_commits: 4'd3, mask: 18'b00_00_00_00_00_00_11_11_11,
                kill_valid: 1'b1, kill_at: 4'd2, pc_base: 38'h4000, default: '0};
    rows[4] = '{n_grp: 4'd9, exp_commits: 4'd8, exp_full: 1'b1,
                mask: 18'b11_11_11_11_11_11_11_11_11,
                pc_base: 38'h5000, complete: 1'b1, default: '0};
    rows[5] = '{n_grp: 4'd1, exp_commits: 4'd1, mask: 18'b00_00_00_00_00_00_00_00_11,
                br_valid: 1'b1, br_grp: 4'd0, br_slot: 1'b1, br_vaddr: 39'h12_3456_789a,
                pc_base: 38'h6000, complete: 1'b1, default: '0};
  endtask

  // Fibonacci LFSR, taps 16, 14, 13 and 11.
  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  // A group costs a dispatch, up to two done reports and its commit.
  function automatic int table_ops();
    int ops;
    ops = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      ops += 4 * int'(rows[r].n_grp) + 2;
    end
    return ops;
  endfunction

  function automatic logic [VADDR_W-1:1] group_pc(input scen_t s, input int g);
    return s.pc_base + (VADDR_W-1)'(4 * g);
  endfunction

  function automatic disp_grp_t make_group(input scen_t s, input int g);
    disp_grp_t grp;
    grp = '0;
    grp.grp_id  = s.mask[g];
    grp.pc_addr = group_pc(s, g);
    for (int d = 0; d < DISP_SIZE; d++) begin
      grp.inst[d].inst      = 32'h0000_0013 + 32'(16 * g + d);
      grp.inst[d].is_branch = s.br_valid && (g == int'(s.br_grp)) && (d == int'(s.br_slot));
    end
    grp.br_included      = s.br_valid && (g == int'(s.br_grp));
    grp.tlb_except_valid = s.tlb_valid[g];
    grp.tlb_except_cause = except_t'(s.tlb_cause);
    return grp;
  endfunction

  // Oldest flagged slot wins, a completion cause replaces the TLB cause.
  function automatic commit_t expect_commit(input scen_t s, input int g,
                                            input logic [CMT_ID_W-1:0] id);
    commit_t c;
    logic    found;
    logic    from_done;
    c = '0;
    found = 1'b0;
    c.cmt_id  = id;
    c.grp_id  = s.mask[g];
    c.pc_addr = group_pc(s, g);
    c.dead    = s.kill_valid && (g <= int'(s.kill_at));
    for (int d = 0; d < DISP_SIZE; d++) begin
      from_done = s.complete && s.exc_valid[g][d];
      if (!c.dead && !found && s.mask[g][d] && (s.tlb_valid[g] || from_done)) begin
        found = 1'b1;
        c.except_valid   = 1'b1;
        c.except_slot[d] = 1'b1;
        c.except_type    = except_t'(from_done ? s.exc_type[d] : s.tlb_cause);
      end
    end
    if (s.br_valid && (g == int'(s.br_grp))) begin
      c.br_upd_info.upd_valid[s.br_slot]    = 1'b1;
      c.br_upd_info.upd_br_vaddr[s.br_slot] = s.br_vaddr;
    end
    return c;
  endfunction

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_commit(input string name, input commit_t exp, input commit_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_ready(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected ready %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cmt_id(input string name, input logic [CMT_ID_W-1:0] exp,
                              input logic [CMT_ID_W-1:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected cmt_id %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic send_done(input logic [CMT_ID_W-1:0] id, input int d, input logic exc_v,
                           input logic [3:0] exc_t);
    logic port;
    if (next_rand_bit()) begin
      next_cycle();
    end
    port = next_rand_bit();
    i_done_rpt[port].valid     = 1'b1;
    i_done_rpt[port].cmt_id    = id;
    i_done_rpt[port].grp_id    = DISP_SIZE'(1 << d);
    i_done_rpt[port].exc_valid = exc_v;
    i_done_rpt[port].exc_type  = except_t'(exc_t);
    next_cycle();
    i_done_rpt[port] = '0;
  endtask

  task automatic run_row(input int r);
    scen_t               s;
    logic [CMT_ID_W-1:0] ids [MAX_GRP];
    int                  base_cnt;
    int                  g;
    s = rows[r];
    base_cnt = commit_cnt;
    for (int k = 0; k < int'(s.n_grp); k++) begin
      i_disp       = make_group(s, k);
      i_disp_valid = 1'b1;
      i_kill       = s.kill_valid && (k == int'(s.kill_at));
      ids[k]       = next_id;
      check_cmt_id(row_name[r], ids[k], o_disp_cmt_id);
      if (k < int'(s.exp_commits)) begin
        next_id = next_id + CMT_ID_W'(1);
      end
      next_cycle();
    end
    i_disp_valid = 1'b0;
    i_kill       = 1'b0;
    if (s.exp_full) begin
      check_ready(row_name[r], 1'b0, o_disp_ready);
    end
    if (s.br_valid) begin
      i_br_upd.update = 1'b1;
      i_br_upd.cmt_id = ids[s.br_grp];
      i_br_upd.grp_id = 2'b01 << s.br_slot;
      i_br_upd.vaddr  = s.br_vaddr;
      next_cycle();
      i_br_upd = '0;
    end
    if (s.complete) begin
      for (int k = 0; k < int'(s.exp_commits); k++) begin
        g = s.reverse ? int'(s.exp_commits) - 1 - k : k;
        for (int d = 0; d < DISP_SIZE; d++) begin
          if (s.mask[g][d]) begin
            send_done(ids[g], d, s.exc_valid[g][d], s.exc_type[d]);
          end
        end
      end
    end
    wait (commit_cnt >= base_cnt + int'(s.exp_commits));
    for (int k = 0; k < int'(s.exp_commits); k++) begin
      check_commit(row_name[r], expect_commit(s, k, ids[k]), got_q.pop_front());
    end
    repeat (3) next_cycle();
    if (commit_cnt != base_cnt + int'(s.exp_commits)) begin
      $display("Extra commit seen after test %s", row_name[r]);
      stop_run();
    end
    check_ready(row_name[r], 1'b1, o_disp_ready);
  endtask

  initial begin
    wait (table_built);
    repeat (table_ops() * 40) @(posedge i_clk);
    $display("Timeout: the ROB stopped making progress");
    stop_run();
  end

  initial begin
    i_reset_n     = 1'b0;
    i_disp_valid  = 1'b0;
    i_disp        = '0;
    i_done_rpt[0] = '0;
    i_done_rpt[1] = '0;
    i_br_upd      = '0;
    i_kill        = 1'b0;
    next_id       = '0;
    build_table();
    table_built = 1'b1;
    repeat (4) @(posedge i_clk);
    #1;
    i_reset_n = 1'b1;
    check_ready("reset", 1'b1, o_disp_ready);
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- hdl/rob_top.sv
module rob_top #(
  parameter int ROB_DEPTH    = 8,
  parameter int CMT_BUS_SIZE = 2
) (
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_disp_valid,
  input  rob_pkg::disp_grp_t           i_disp,
  input  rob_pkg::done_rpt_t           i_done_rpt [CMT_BUS_SIZE],
  input  rob_pkg::br_upd_t             i_br_upd,
  input  logic                         i_kill,
  output logic                         o_disp_ready,
  output logic [rob_pkg::CMT_ID_W-1:0] o_disp_cmt_id,
  output logic                         o_commit_valid,
  output rob_pkg::commit_t             o_commit
);

  import rob_pkg::*;

  logic [ROB_DEPTH-1:0] w_load_oh;
  logic [ROB_DEPTH-1:0] w_all_done;
  logic [ROB_DEPTH-1:0] w_commit_finish;
  logic                 w_retire;
  rob_entry_t           w_entries [ROB_DEPTH];

  // Depth must be a power of two that the commit id can index.
  if ((ROB_DEPTH < 2) || (ROB_DEPTH > 16) || ((ROB_DEPTH & (ROB_DEPTH - 1)) != 0)) begin : g_bad_depth
    $error("ROB_DEPTH must be a power of two from 2 to 16");
  end

  rob_alloc_ctrl #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_alloc (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .i_retire      (w_retire),
    .o_disp_ready  (o_disp_ready),
    .o_load_oh     (w_load_oh),
    .o_disp_cmt_id (o_disp_cmt_id)
  );

  // The dispatch bundle goes to every entry, the load select picks one.
  for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_entry
    rob_entry #(
      .ROB_DEPTH    (ROB_DEPTH),
      .CMT_BUS_SIZE (CMT_BUS_SIZE),
      .ENTRY_IDX    (i)
    ) u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_load           (w_load_oh[i]),
      .i_load_grp       (i_disp),
      .i_done_rpt       (i_done_rpt),
      .i_br_upd         (i_br_upd),
      .i_kill           (i_kill),
      .i_commit_finish  (w_commit_finish[i]),
      .o_entry          (w_entries[i]),
      .o_block_all_done (w_all_done[i])
    );
  end

  rob_commit_ctrl #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_commit (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_entries       (w_entries),
    .i_all_done      (w_all_done),
    .o_commit_finish (w_commit_finish),
    .o_retire        (w_retire),
    .o_commit_valid  (o_commit_valid),
    .o_commit        (o_commit)
  );

endmodule

//--- hdl/rob_commit_ctrl.sv
module rob_commit_ctrl #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  rob_pkg::rob_entry_t  i_entries [ROB_DEPTH],
  input  logic [ROB_DEPTH-1:0] i_all_done,
  output logic [ROB_DEPTH-1:0] o_commit_finish,
  output logic                 o_retire,
  output logic                 o_commit_valid,
  output rob_pkg::commit_t     o_commit
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);

  // Head index with its wrap bit on top.
  logic [IDX_W:0]       r_head;
  logic [IDX_W-1:0]     w_head_idx;
  rob_entry_t           w_head;
  logic                 w_retire;
  logic [DISP_SIZE-1:0] w_exc_mask;
  logic [DISP_SIZE-1:0] w_exc_slot;
  except_t              w_exc_type;
  commit_t              w_commit;
  logic                 r_commit_valid;
  commit_t              r_commit;

  assign w_head_idx = r_head[IDX_W-1:0];
  assign w_head     = i_entries[w_head_idx];

  // Head retires once every slot is done, or at once when it is dead.
  assign w_retire = w_head.valid & (i_all_done[w_head_idx] | w_head.dead);
  assign o_retire = w_retire;

  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      o_commit_finish[i] = w_retire && (w_head_idx == IDX_W'(i));
    end
  end

  assign w_exc_mask = w_head.grp_id & w_head.except_valid;

  // Oldest slot wins, so scan from the top down.
  always_comb begin
    w_exc_slot = '0;
    w_exc_type = EXC_NONE;
    for (int d = DISP_SIZE - 1; d >= 0; d--) begin
      if (w_exc_mask[d]) begin
        w_exc_slot    = '0;
        w_exc_slot[d] = 1'b1;
        w_exc_type    = w_head.except_type[d];
      end
    end
  end

  always_comb begin
    w_commit.cmt_id       = CMT_ID_W'(r_head);
    w_commit.grp_id       = w_head.grp_id;
    w_commit.pc_addr      = w_head.pc_addr;
    w_commit.dead         = w_head.dead;
    w_commit.except_valid = !w_head.dead && (|w_exc_mask);
    w_commit.except_slot  = w_head.dead ? '0 : w_exc_slot;
    w_commit.except_type  = w_head.dead ? EXC_NONE : w_exc_type;
    w_commit.br_upd_info  = w_head.br_upd_info;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_head <= '0;
    end else if (w_retire) begin
      r_head <= r_head + 1'b1;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_commit_valid <= 1'b0;
    end else begin
      r_commit_valid <= w_retire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_retire) begin
      r_commit <= w_commit;
    end
  end

  assign o_commit_valid = r_commit_valid;
  assign o_commit       = r_commit;

  a_finish_onehot: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(o_commit_finish)
  ) else $error("Commit finish raised for more than one entry");

endmodule

//--- hdl/rob_alloc_ctrl.sv
module rob_alloc_ctrl #(
  parameter int ROB_DEPTH = 8
) (
  input  logic                          i_clk,
  input  logic                          i_reset_n,
  input  logic                          i_disp_valid,
  input  logic                          i_retire,
  output logic                          o_disp_ready,
  output logic [ROB_DEPTH-1:0]          o_load_oh,
  output logic [rob_pkg::CMT_ID_W-1:0]  o_disp_cmt_id
);

  import rob_pkg::*;

  localparam int IDX_W = $clog2(ROB_DEPTH);
  localparam int CNT_W = $clog2(ROB_DEPTH + 1);

  // Tail index with its wrap bit on top.
  logic [IDX_W:0]   r_tail;
  logic [CNT_W-1:0] r_count;
  logic             w_push;

  assign o_disp_ready  = (r_count < CNT_W'(ROB_DEPTH));
  assign w_push        = i_disp_valid & o_disp_ready;
  assign o_disp_cmt_id = CMT_ID_W'(r_tail);

  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      o_load_oh[i] = w_push && (r_tail[IDX_W-1:0] == IDX_W'(i));
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_tail <= '0;
    end else if (w_push) begin
      r_tail <= r_tail + 1'b1;
    end
  end

  // Occupancy moves only when a dispatch and a retire do not cancel.
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_count <= '0;
    end else begin
      case ({w_push, i_retire})
        2'b10: begin
          r_count <= r_count + 1'b1;
        end
        2'b01: begin
          r_count <= r_count - 1'b1;
        end
        default: begin
          r_count <= r_count;
        end
      endcase
    end
  end

  a_count_bound: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_count <= CNT_W'(ROB_DEPTH)
  ) else $error("ROB occupancy above depth");

  a_full_no_alloc: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_disp_valid && (r_count == CNT_W'(ROB_DEPTH))) |=> (r_tail == $past(r_tail))
  ) else $error("Dispatch allocated into a full ROB");

  a_retire_nonempty: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_retire |-> (r_count != '0)
  ) else $error("Retire with an empty ROB");

endmodule

//--- hdl/rob_entry.sv
module rob_entry #(
  parameter int ROB_DEPTH    = 8,
  parameter int CMT_BUS_SIZE = 2,
  parameter int ENTRY_IDX    = 0
) (
  input  logic                i_clk,
  input  logic                i_reset_n,
  input  logic                i_load,
  input  rob_pkg::disp_grp_t  i_load_grp,
  input  rob_pkg::done_rpt_t  i_done_rpt [CMT_BUS_SIZE],
  input  rob_pkg::br_upd_t    i_br_upd,
  input  logic                i_kill,
  input  logic                i_commit_finish,
  output rob_pkg::rob_entry_t o_entry,
  output logic                o_block_all_done
);

  import rob_pkg::*;

  localparam int               IDX_W  = $clog2(ROB_DEPTH);
  localparam logic [IDX_W-1:0] MY_IDX = IDX_W'(ENTRY_IDX);

  rob_entry_t                             r_entry;
  logic [DISP_SIZE-1:0][CMT_BUS_SIZE-1:0] w_done_hit;
  logic [DISP_SIZE-1:0]                   w_done_valid;
  logic [DISP_SIZE-1:0]                   w_done_exc_valid;
  except_t [DISP_SIZE-1:0]                w_done_exc_type;
  logic [DISP_SIZE-1:0]                   w_br_hit;
  logic                                   w_clear;

  // Done reports addressed to this entry, one slot at a time.
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_done_valid[d]     = 1'b0;
      w_done_exc_valid[d] = 1'b0;
      w_done_exc_type[d]  = EXC_NONE;
      for (int c = 0; c < CMT_BUS_SIZE; c++) begin
        w_done_hit[d][c] = i_done_rpt[c].valid &&
                           (i_done_rpt[c].cmt_id[IDX_W-1:0] == MY_IDX) &&
                           (i_done_rpt[c].grp_id == DISP_SIZE'(1 << d));
        // At most one port hits a slot, so the last hit is the only one.
        if (w_done_hit[d][c]) begin
          w_done_valid[d]     = 1'b1;
          w_done_exc_valid[d] = i_done_rpt[c].exc_valid;
          w_done_exc_type[d]  = i_done_rpt[c].exc_type;
        end
      end
    end
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_br_hit[d] = i_br_upd.update &&
                    (i_br_upd.cmt_id[IDX_W-1:0] == MY_IDX) &&
                    (i_br_upd.grp_id == DISP_SIZE'(1 << d));
    end
  end

  assign w_clear = i_commit_finish & (o_block_all_done | r_entry.dead);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_entry <= '0;
    end else if (i_load) begin
      r_entry.valid          <= 1'b1;
      // A group loaded during a kill is already dead.
      r_entry.dead           <= i_kill;
      r_entry.grp_id         <= i_load_grp.grp_id;
      r_entry.done_grp_id    <= '0;
      r_entry.pc_addr        <= i_load_grp.pc_addr;
      r_entry.inst           <= i_load_grp.inst;
      r_entry.is_br_included <= i_load_grp.br_included;
      r_entry.except_valid   <= {DISP_SIZE{i_load_grp.tlb_except_valid}};
      for (int d = 0; d < DISP_SIZE; d++) begin
        r_entry.except_type[d] <= i_load_grp.tlb_except_cause;
      end
      r_entry.br_upd_info    <= '0;
    end else if (r_entry.valid) begin
      if (w_clear) begin
        r_entry.valid <= 1'b0;
      end else begin
        r_entry.done_grp_id <= r_entry.done_grp_id | w_done_valid;
        for (int d = 0; d < DISP_SIZE; d++) begin
          // A completion without an exception keeps any TLB cause.
          if (w_done_valid[d] && w_done_exc_valid[d]) begin
            r_entry.except_valid[d] <= 1'b1;
            r_entry.except_type[d]  <= w_done_exc_type[d];
          end
          if (w_br_hit[d]) begin
            r_entry.br_upd_info.upd_valid[d]    <= 1'b1;
            r_entry.br_upd_info.upd_br_vaddr[d] <= i_br_upd.vaddr;
          end
        end
      end
      r_entry.dead <= r_entry.dead | i_kill;
    end
  end

  assign o_entry          = r_entry;
  assign o_block_all_done = r_entry.valid & (r_entry.grp_id == r_entry.done_grp_id);

  for (genvar d = 0; d < DISP_SIZE; d++) begin : g_slot_chk
    a_done_slot_unique: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      r_entry.valid |-> $onehot0(w_done_hit[d])
    ) else $error("Two done reports hit entry %0d slot %0d", ENTRY_IDX, d);
  end

  for (genvar c = 0; c < CMT_BUS_SIZE; c++) begin : g_port_chk
    a_done_in_grp: assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      (r_entry.valid && i_done_rpt[c].valid &&
       (i_done_rpt[c].cmt_id[IDX_W-1:0] == MY_IDX))
      |-> ((i_done_rpt[c].grp_id & ~r_entry.grp_id) == '0)
    ) else $error("Done report on port %0d targets an empty slot", c);
  end

endmodule

//--- hdl/rob_pkg.sv
package rob_pkg;

  localparam int DISP_SIZE = 2;
  localparam int VADDR_W   = 39;
  // Entry index plus the wrap bit, up to a depth of eight.
  localparam int CMT_ID_W  = 4;

  // RISC-V mcause codes.
  typedef enum logic [3:0] {
    EXC_NONE            = 4'd0,
    EXC_ILLEGAL_INST    = 4'd2,
    EXC_BREAKPOINT      = 4'd3,
    EXC_ECALL           = 4'd8,
    EXC_INST_PAGE_FAULT = 4'd12,
    EXC_LOAD_PAGE_FAULT = 4'd13
  } except_t;

  typedef struct packed {
    logic [31:0] inst;
    logic        is_branch;
  } disp_t;

  typedef struct packed {
    logic [DISP_SIZE-1:0]        grp_id;
    logic [VADDR_W-1:1]          pc_addr;
    disp_t [DISP_SIZE-1:0]       inst;
    logic                        br_included;
    logic                        tlb_except_valid;
    except_t                     tlb_except_cause;
  } disp_grp_t;

  typedef struct packed {
    logic                        valid;
    logic [CMT_ID_W-1:0]         cmt_id;
    logic [DISP_SIZE-1:0]        grp_id;
    logic                        exc_valid;
    except_t                     exc_type;
  } done_rpt_t;

  typedef struct packed {
    logic                        update;
    logic [CMT_ID_W-1:0]         cmt_id;
    logic [DISP_SIZE-1:0]        grp_id;
    logic [VADDR_W-1:0]          vaddr;
  } br_upd_t;

  typedef struct packed {
    logic [DISP_SIZE-1:0]              upd_valid;
    logic [DISP_SIZE-1:0][VADDR_W-1:0] upd_br_vaddr;
  } br_upd_info_t;

  typedef struct packed {
    logic                        valid;
    logic                        dead;
    logic [DISP_SIZE-1:0]        grp_id;
    logic [DISP_SIZE-1:0]        done_grp_id;
    logic [VADDR_W-1:1]          pc_addr;
    disp_t [DISP_SIZE-1:0]       inst;
    logic                        is_br_included;
    logic [DISP_SIZE-1:0]        except_valid;
    except_t [DISP_SIZE-1:0]     except_type;
    br_upd_info_t                br_upd_info;
  } rob_entry_t;

  typedef struct packed {
    logic [CMT_ID_W-1:0]         cmt_id;
    logic [DISP_SIZE-1:0]        grp_id;
    logic [VADDR_W-1:1]          pc_addr;
    logic                        dead;
    logic                        except_valid;
    logic [DISP_SIZE-1:0]        except_slot;
    except_t                     except_type;
    br_upd_info_t                br_upd_info;
  } commit_t;

endpackage
